//--- verification/permutCheck_stimulus.txt
// columns: isBotValid top bot expected, all hex
// top and bot are 128-bit truth tables, expected is the 24-bit result word
1 ffffffffffffffffffffffffffffffff ffffffffffffffffffffffffffffffff ffffff
1 00000000000000000000000000000000 00000000000000000000000000000000 ffffff
1 00000000000000000000000000000000 ffffffffffffffffffffffffffffffff 000000
0 ffffffffffffffffffffffffffffffff ffffffffffffffffffffffffffffffff 000000
1 0000000000000000ff000000ff00ff00 0000000000000000ff000000ff00ff00 800000
1 ff000000ff000000ff000000ff000000 ff000000ff000000ff000000ff000000 c30000
1 00ff000000ff00ff0000000000000000 0000000000000000ff000000ff00ff00 000020
1 0000ffff00000000000000ff00000000 0000000000000000ff000000ff00ff00 000040
1 0000000000000000ff00ff000000ff00 0000000000000000ff000000ff00ff00 200000
1 ffffffff000000000000000000000000 ff000000ff000000ff000000ff000000 0000cc
1 0123456789abcdef0123456789abcdef 00000000000000000000000000000000 ffffff
0 0123456789abcdef0123456789abcdef 00000000000000000000000000000000 000000
1 ffffffffffffff00ffffff00ff000000 ffffffffffffff00ffffff00ff000000 ffffff
1 ffffffffffffff00ffffff00ff000000 a5a5a5a5a5a5a500a5a5a500a5000000 ffffff
1 0000000000000000000000000000003c 0000000000000000000000000000000c ffffff
1 0000000000000000000000000000003c 00000000000000000000000000000042 000000

//--- list.f
+incdir+include
rtl/permutFuncPkg.sv
rtl/permutResultPkg.sv
rtl/permutCheck24.sv
rtl/permutCheckCtrl.sv
rtl/permutResultTally.sv
rtl/permutCheckUnit.sv
verification/permutCheckUnit_tb.sv

//--- Bender.yml
package:
  name: permut_check

export_include_dirs:
  - include

sources:
  - files:
      - rtl/permutFuncPkg.sv
      - rtl/permutResultPkg.sv
      - rtl/permutCheck24.sv
      - rtl/permutCheckCtrl.sv
      - rtl/permutResultTally.sv
      - rtl/permutCheckUnit.sv
  - target: test
    files:
      - verification/permutCheckUnit_tb.sv

//--- verification/permutCheckUnit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "permutCheck_params.svh"

module permutCheckUnit_tb;

    import permutFuncPkg::*;
    import permutResultPkg::*;

    localparam int maxVectors = 64;
    localparam int ackLimit = 10; // cycles allowed for one ack edge
    localparam int cyclesPerVector = 5 + 8; // worst idle gap plus one full handshake

    logic clk;
    logic rstN;
    logic req;
    logic isBotValid;
    funcTable_t top;
    funcTable_t bot;
    logic ack;
    permutResults_t results;
    logic [`PERMUT_GROUPS-1:0] groupAny;
    logic [`PERMUT_TALLY_WIDTH-1:0] tally;

    logic validMem [maxVectors];
    funcTable_t topMem [maxVectors];
    funcTable_t botMem [maxVectors];
    logic [`PERMUT_COUNT-1:0] expMem [maxVectors];
    int vecCount;
    logic loadDone; // releases the watchdog once the vector count is known
    int valueErrors;
    int protocolErrors;
    logic [31:0] rngState;
    logic [`PERMUT_TALLY_WIDTH-1:0] expTally; // running sum of expected set bits

    permutCheckUnit permutCheckUnit_inst (
        .clk(clk),
        .rstN(rstN),
        .req(req),
        .isBotValid(isBotValid),
        .top(top),
        .bot(bot),
        .ack(ack),
        .results(results),
        .groupAny(groupAny),
        .tally(tally)
    );

    always #4 clk = ~clk; // 8 ns period

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int countOnes(input logic [`PERMUT_COUNT-1:0] word);
        int n;
        n = 0;
        for (int i = 0; i < `PERMUT_COUNT; i++)
            n += word[i];
        return n;
    endfunction

    // group 3 sits in the top six bits, one flag per group
    function automatic logic [`PERMUT_GROUPS-1:0] groupFlags(
        input logic [`PERMUT_COUNT-1:0] word
    );
        logic [`PERMUT_GROUPS-1:0] f;
        for (int g = 0; g < `PERMUT_GROUPS; g++)
            f[g] = |word[g*6 +: 6];
        return f;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            valueErrors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // counts falling edges until ack reaches level, gives up after ackLimit
    task automatic waitAck(input logic level, output int cycles);
        cycles = 0;
        while (cycles < ackLimit) begin
            @(negedge clk);
            cycles++;
            if (ack === level)
                break;
        end
        assert (ack === level) else begin
            protocolErrors++;
            $display("ack never went to %b within %0d cycles", level, ackLimit);
        end
    endtask

    task automatic checkHeld(input string name, input int idx);
        checkValue({name, " held ack"}, 32'd1, {31'd0, ack});
        checkValue({name, " held results"}, expMem[idx], results); // must not move
    endtask

    // data lines are skipped past comments by letting $fscanf fail on them
    task automatic loadVectors(output logic ok);
        int fd;
        int n;
        logic [8*200-1:0] lineBuf;
        logic [3:0] v;
        funcTable_t t;
        funcTable_t b;
        logic [`PERMUT_COUNT-1:0] e;
        vecCount = 0;
        fd = $fopen("verification/permutCheck_stimulus.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && vecCount < maxVectors) begin
                n = $fscanf(fd, "%h %h %h %h", v, t, b, e);
                if (n == 4) begin
                    validMem[vecCount] = v[0];
                    topMem[vecCount] = t;
                    botMem[vecCount] = b;
                    expMem[vecCount] = e;
                    vecCount++;
                end else begin
                    n = $fgets(lineBuf, fd); // drop the comment line
                end
            end
            $fclose(fd);
        end
        ok = (vecCount > 0);
    endtask

    task automatic runVector(input int idx);
        int idle;
        int hold;
        int cycles;
        string name;
        name = $sformatf("vector %0d", idx);
        rngState = nextRandom(rngState);
        idle = rngState % 6; // 0..5 quiet cycles before req
        hold = (rngState >> 8) % 3; // extra cycles req stays high after the tally check
        repeat (idle) @(negedge clk);
        isBotValid = validMem[idx]; // req and ack both low here
        top = topMem[idx];
        bot = botMem[idx];
        req = 1'b1;
        waitAck(1'b1, cycles);
        checkValue({name, " ack rise cycles"}, 32'd2, cycles);
        checkValue({name, " results"}, expMem[idx], results);
        checkValue({name, " groupAny"}, groupFlags(expMem[idx]), groupAny);
        expTally = expTally + countOnes(expMem[idx]);
        @(negedge clk);
        checkValue({name, " tally"}, expTally, tally); // one cycle behind ack
        checkHeld(name, idx);
        repeat (hold) begin
            @(negedge clk);
            checkHeld(name, idx);
        end
        req = 1'b0;
        waitAck(1'b0, cycles);
        checkValue({name, " ack fall cycles"}, 32'd1, cycles);
    endtask

    initial begin
        logic loadOk;
        clk = 1'b0;
        rstN = 1'b0;
        req = 1'b0;
        isBotValid = 1'b0;
        top = '0;
        bot = '0;
        valueErrors = 0;
        protocolErrors = 0;
        rngState = 32'h0073b840;
        expTally = '0;
        loadDone = 1'b0;
        loadVectors(loadOk);
        if (!loadOk) begin
            $display("stimulus file missing or without any vector");
            $display("Simulation failed");
            $finish;
        end else begin
            loadDone = 1'b1;
            repeat (4) @(negedge clk); // four rising edges in reset
            rstN = 1'b1;
            @(negedge clk);
            checkValue("reset ack", 32'd0, {31'd0, ack});
            checkValue("reset results", 32'd0, results);
            checkValue("reset groupAny", 32'd0, groupAny);
            checkValue("reset tally", 32'd0, tally);
            for (int i = 0; i < vecCount; i++)
                runVector(i);
            $display("errors: value %0d, protocol %0d", valueErrors, protocolErrors);
            if (valueErrors == 0 && protocolErrors == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

    // budget is twice the worst case per vector plus reset
    initial begin
        wait (loadDone === 1'b1);
        repeat ((vecCount * cyclesPerVector + 4) * 2 + 20) @(posedge clk);
        $display("watchdog expired before all vectors were run");
        $display("errors: value %0d, protocol %0d", valueErrors, protocolErrors);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/permutCheckUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "permutCheck_params.svh"

module permutCheckUnit (
    input logic clk,
    input logic rstN,
    input logic req,
    input logic isBotValid,
    input permutFuncPkg::funcTable_t top,
    input permutFuncPkg::funcTable_t bot,
    output logic ack,
    output permutResultPkg::permutResults_t results,
    output logic [`PERMUT_GROUPS-1:0] groupAny,
    output logic [`PERMUT_TALLY_WIDTH-1:0] tally
);

    import permutFuncPkg::*;
    import permutResultPkg::*;

    funcTable_t capTop; // operands held for the checker
    funcTable_t capBot;
    logic capValid;
    permutResults_t checkResult; // combinational, settles during stCheck
    logic resultStrobe; // one pulse per request

    permutCheckCtrl permutCheckCtrl_inst (
        .clk(clk),
        .rstN(rstN),
        .req(req),
        .isBotValid(isBotValid),
        .top(top),
        .bot(bot),
        .checkResult(checkResult),
        .ack(ack),
        .resultStrobe(resultStrobe),
        .capValid(capValid),
        .capTop(capTop),
        .capBot(capBot),
        .results(results)
    );

    permutCheck24 permutCheck24_inst (
        .top(capTop),
        .bot(capBot),
        .isBotValid(capValid),
        .validBotPermutations(checkResult)
    );

    permutResultTally permutResultTally_inst (
        .clk(clk),
        .rstN(rstN),
        .resultStrobe(resultStrobe),
        .results(results), // registered word, tally lags ack by one cycle
        .groupAny(groupAny),
        .tally(tally)
    );

endmodule

`default_nettype wire

//--- rtl/permutResultTally.sv
`timescale 1ns/1ps
`default_nettype none

`include "permutCheck_params.svh"

module permutResultTally (
    input logic clk,
    input logic rstN,
    input logic resultStrobe,
    input permutResultPkg::permutResults_t results,
    output logic [`PERMUT_GROUPS-1:0] groupAny,
    output logic [`PERMUT_TALLY_WIDTH-1:0] tally
);

    localparam int countWidth = $clog2(`PERMUT_COUNT + 1); // holds 0..24

    logic [countWidth-1:0] setCount;

    // any permutation of the group holds, read through the grouped view
    always_comb begin
        for (int g = 0; g < `PERMUT_GROUPS; g++)
            groupAny[g] = |results.groups[g];
    end

    // population count over the flat view
    always_comb begin
        setCount = '0;
        for (int i = 0; i < `PERMUT_COUNT; i++)
            setCount = setCount + countWidth'(results.flat[i]);
    end

    always_ff @(posedge clk) begin
        if (!rstN)
            tally <= '0;
        else if (resultStrobe) // once per completed request
            tally <= tally + {{(`PERMUT_TALLY_WIDTH-countWidth){1'b0}}, setCount};
    end

endmodule

`default_nettype wire

//--- rtl/permutCheckCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module permutCheckCtrl (
    input logic clk,
    input logic rstN,
    input logic req,
    input logic isBotValid,
    input permutFuncPkg::funcTable_t top,
    input permutFuncPkg::funcTable_t bot,
    input permutResultPkg::permutResults_t checkResult,
    output logic ack,
    output logic resultStrobe,
    output logic capValid,
    output permutFuncPkg::funcTable_t capTop,
    output permutFuncPkg::funcTable_t capBot,
    output permutResultPkg::permutResults_t results
);

    localparam logic [1:0] stIdle = 2'd0; // waiting for req
    localparam logic [1:0] stCheck = 2'd1; // operands held, checker settling
    localparam logic [1:0] stDone = 2'd2; // ack high until req drops

    logic [1:0] state;
    logic capture;

    assign capture = (state == stIdle) && req && !ack; // new request seen

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stIdle;
            ack <= 1'b0;
            resultStrobe <= 1'b0;
            results <= '0;
        end else begin
            resultStrobe <= 1'b0; // single cycle pulse
            case (state)
                stIdle: begin
                    if (capture)
                        state <= stCheck;
                end
                stCheck: begin
                    results <= checkResult; // checker output from captured operands
                    resultStrobe <= 1'b1;
                    ack <= 1'b1;
                    state <= stDone;
                end
                stDone: begin
                    if (!req) begin // requester finished, release ack
                        ack <= 1'b0;
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // operand registers, loaded only on capture
    always_ff @(posedge clk) begin
        if (capture) begin
            capTop <= top;
            capBot <= bot;
            capValid <= isBotValid;
        end
    end

endmodule

`default_nettype wire

//--- rtl/permutCheck24.sv
`timescale 1ns/1ps
`default_nettype none

`include "permutCheck_params.svh"

module permutCheck24 (
    input permutFuncPkg::funcTable_t top,
    input permutFuncPkg::funcTable_t bot,
    input logic isBotValid,
    output permutResultPkg::permutResults_t validBotPermutations
);

    import permutFuncPkg::*;
    import permutResultPkg::*;

    localparam int sliceWidth = $bits(funcSlice_t); // 8 bits for vars e..g
    localparam int sliceCount = `PERMUT_FUNC_WIDTH / sliceWidth; // one per a..d setting

    // two-var slices where entry k and k+3 are complements
    // order ab, ac, ad, cd, bd, bc
    localparam logic [3:0] twoVarSlice [6] = '{
        4'b0011, 4'b0101, 4'b1001, 4'b1100, 4'b1010, 4'b0110
    };

    // twoTwo flavor holding {removed, remaining var of slot f} per removed var
    localparam int twoTwoIdx [4][3] = '{
        '{0, 1, 2}, // ab ac ad with a removed
        '{0, 5, 4}, // ab bc bd with b removed
        '{5, 1, 3}, // bc ac cd with c removed
        '{4, 3, 2}  // bd cd ad with d removed
    };

    // slot assignment for the six 3-var orderings with the msb result first
    localparam int subPerm [6][3] = '{
        '{0, 1, 2}, '{0, 2, 1}, '{1, 0, 2}, '{1, 2, 0}, '{2, 0, 1}, '{2, 1, 0}
    };

    // the three vars left in group order once one is pinned to location a
    // b c d without a, a c d without b, b a d without c, b c a without d
    function automatic int remainingVar(input int removed, input int slot);
        int v;
        v = slot + 1;
        if (v == removed)
            return 0; // swapped with a
        return v;
    endfunction

    wire funcSlice_t topParts [sliceCount];
    wire funcSlice_t botParts [sliceCount];
    wire sharedAll; // slices 0000 and 1111 map onto themselves
    wire sharedGated;
    wire [15:0] oneThree; // one-var and three-var slices at [loc*4+flavor]
    wire [17:0] twoTwo; // two-var shapes XX__ X_X_ X__X at [shape*6+flavor]

    for (genvar s = 0; s < sliceCount; s++) begin : gSlice
        assign topParts[s] = top[s*sliceWidth +: sliceWidth];
        assign botParts[s] = bot[s*sliceWidth +: sliceWidth];
    end

    // bot must imply top in every bit of a compared slice pair
    assign sharedAll = &({topParts[0], topParts[sliceCount-1]}
                        | ~{botParts[0], botParts[sliceCount-1]});
    assign sharedGated = sharedAll & isBotValid; // kills every result when bot is invalid

    // flavor var of bot lands on location var of top
    // single-var slice and its complement checked together
    for (genvar loc = 0; loc < 4; loc++) begin : gOneLoc
        for (genvar flav = 0; flav < 4; flav++) begin : gOneFlav
            assign oneThree[loc*4+flav] =
                &({topParts[1 << loc], topParts[15 ^ (1 << loc)]}
                 | ~{botParts[1 << flav], botParts[15 ^ (1 << flav)]});
        end
    end

    // location pair ab/ac/ad of top against any var pair of bot
    for (genvar shape = 0; shape < 3; shape++) begin : gTwoShape
        for (genvar flav = 0; flav < 6; flav++) begin : gTwoFlav
            assign twoTwo[shape*6+flav] =
                &({topParts[twoVarSlice[shape]], topParts[twoVarSlice[shape+3]]}
                 | ~{botParts[twoVarSlice[flav]], botParts[twoVarSlice[(flav+3)%6]]});
        end
    end

    // one 6-way check per var pinned to location a
    for (genvar r = 0; r < `PERMUT_GROUPS; r++) begin : gGroup
        wire shared6; // common terms plus r held at location a
        wire [8:0] oneTwo6; // slot per location b..d at [loc*3+slot]
        wire permutGroup_t groupBits;

        assign shared6 = sharedGated & oneThree[r];

        for (genvar i = 0; i < 3; i++) begin : gLoc
            for (genvar f = 0; f < 3; f++) begin : gSlot
                // slot f var at location i+1 and the pair it forms with r
                assign oneTwo6[i*3+f] = oneThree[4*(i+1)+remainingVar(r, f)]
                                      & twoTwo[6*i+twoTwoIdx[r][f]];
            end
        end

        for (genvar p = 0; p < 6; p++) begin : gPermut
            assign groupBits[5-p] = &{shared6,
                                      oneTwo6[0+subPerm[p][0]],
                                      oneTwo6[3+subPerm[p][1]],
                                      oneTwo6[6+subPerm[p][2]]};
        end

        assign validBotPermutations.groups[`PERMUT_GROUPS-1-r] = groupBits; // ABCD on top
    end

endmodule

`default_nettype wire

//--- rtl/permutResultPkg.sv
`default_nettype none

`include "permutCheck_params.svh"

package permutResultPkg;

    // flags of one group, msb first: xabc, xacb, xbac, xbca, xcab, xcba
    // where x is the var at location a and a..c are the other three in group order
    typedef logic [5:0] permutGroup_t;

    // 24 permutation flags, abcd in the msb, dacb in the lsb
    // groups[3] = ABCD, groups[2] = BACD, groups[1] = CBAD, groups[0] = DBCA
    typedef union packed {
        logic [`PERMUT_COUNT-1:0] flat; // one bit per permutation
        permutGroup_t [`PERMUT_GROUPS-1:0] groups; // same bits split per leading var
    } permutResults_t;

endpackage

`default_nettype wire

//--- rtl/permutFuncPkg.sv
`default_nettype none

`include "permutCheck_params.svh"

package permutFuncPkg;

    // whole truth table, bit index is the input assignment {g,f,e,d,c,b,a}
    typedef logic [`PERMUT_FUNC_WIDTH-1:0] funcTable_t;

    // one of 16 slices, a..d fixed by the slice number
    // e, f, g select the bit inside the slice
    typedef logic [`PERMUT_FUNC_WIDTH/16-1:0] funcSlice_t;

endpackage

`default_nettype wire

//--- include/permutCheck_params.svh
`ifndef PERMUT_CHECK_PARAMS_SVH
`define PERMUT_CHECK_PARAMS_SVH

// truth table of a function of seven variables a..g
`define PERMUT_FUNC_WIDTH 128

// orderings of a, b, c, d
`define PERMUT_COUNT 24

`define PERMUT_GROUPS 4 // six permutations per group, keyed by the var at location a

`define PERMUT_TALLY_WIDTH 32 // running count of valid permutations

`endif
